/* verif/ctrlUnitInput.txt */
// opcode funct eq gt cycles pcWrites aluOp regDst(f = no brWrite) aluSrcB lastPcSource
// All hex; aluOp and aluSrcB from the first execute cycle, pcSource at the last pcWrite
00 20 0 0 9 1 1 1 0 2  // ADD
00 22 1 0 9 1 2 1 0 2  // SUB
00 24 0 1 9 1 3 1 0 2  // AND
08 2a 0 0 9 1 1 0 2 2  // ADDI
04 10 1 0 a 2 1 f 3 2  // BEQ taken
04 10 0 1 a 1 1 f 3 2  // BEQ not taken
05 08 0 0 a 2 1 f 3 2  // BNE taken
05 08 1 0 a 1 1 f 3 2  // BNE not taken
06 04 1 0 a 2 1 f 3 2  // BLE taken on equal
06 04 0 0 a 2 1 f 3 2  // BLE taken on less
06 04 0 1 a 1 1 f 3 2  // BLE not taken
07 0c 0 1 a 2 1 f 3 2  // BGT taken
07 0c 1 0 a 1 1 f 3 2  // BGT not taken
00 0b 0 0 7 1 0 f 0 2  // BREAK
00 13 0 0 8 2 0 f 0 0  // RTE
3f 00 0 0 6 1 1 f 1 2  // Unknown opcode
00 18 0 0 6 1 1 f 1 2  // MULT funct, not decoded
00 3f 1 1 6 1 1 f 1 2  // Unknown funct

/* files.f */
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/controlEncoder.sv
verilog/ctrlUnit.sv
verif/ctrlUnitTb.sv

/* Bender.yml */
package:
  name: ctrl_unit

sources:
  - verilog/ctrlPkg.sv
  - verilog/instrDecoder.sv
  - verilog/stepSequencer.sv
  - verilog/controlEncoder.sv
  - verilog/ctrlUnit.sv
  - target: test
    files:
      - verif/ctrlUnitTb.sv

/* verif/ctrlUnitTb.sv */
`default_nettype none

module ctrlUnitTb;

  import ctrlPkg::*;

  localparam int MaxTests  = 32;
  localparam int FieldsPer = 10;  // Columns per line of the data file

  // Column positions in a data line
  localparam int ColOpcode = 0;
  localparam int ColFunct  = 1;
  localparam int ColEq     = 2;
  localparam int ColGt     = 3;
  localparam int ColCycles = 4;
  localparam int ColPcWr   = 5;
  localparam int ColAluOp  = 6;
  localparam int ColRegDst = 7;  // f when no brWrite is expected
  localparam int ColSrcB   = 8;
  localparam int ColPcSrc  = 9;

  logic                   clk;
  logic                   reset;
  logic [OpcodeWidth-1:0] opcode;
  logic [OffsetWidth-1:0] offset;
  logic                   eq;
  logic                   gt;
  wire                    pcWrite;
  wire                    irWrite;
  wire                    brWrite;
  wire                    abWrite;
  wire                    aluOutWrite;
  wire [AluOpWidth-1:0]   aluOp;
  wire [1:0]              regDst;
  wire [1:0]              aluSrcA;
  wire [1:0]              aluSrcB;
  wire [2:0]              pcSource;
  wire                    rstOut;

  logic [7:0] testData [0:MaxTests*FieldsPer-1];
  int         numTests;
  int         cycleLimit;
  int         cycleCount;
  int         errorCount;
  int         testsFailed;

  ctrlUnit #(
    .MemWaitCycles (3)
  ) u_ctrlUnit (
    .clk         (clk),
    .reset       (reset),
    .opcode      (opcode),
    .offset      (offset),
    .eq          (eq),
    .gt          (gt),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .brWrite     (brWrite),
    .abWrite     (abWrite),
    .aluOutWrite (aluOutWrite),
    .aluOp       (aluOp),
    .regDst      (regDst),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource),
    .rstOut      (rstOut)
  );

  always #2 clk = ~clk;

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Run timed out after %0d cycles while waiting on the DUT", cycleCount);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic driveInputs(input int idx);
    int base;
    base = idx * FieldsPer;
    @(posedge clk);
    opcode <= testData[base+ColOpcode][OpcodeWidth-1:0];
    offset <= {10'h0, testData[base+ColFunct][5:0]};
    eq     <= testData[base+ColEq][0];
    gt     <= testData[base+ColGt][0];
  endtask

  // Outputs sampled on each falling edge from the first reset cycle on
  task automatic checkReset();
    int errorsBefore;
    int rstHigh;
    errorsBefore = errorCount;
    rstHigh      = 0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i == 7) reset <= 1'b0;
      @(negedge clk);
      if (rstOut === 1'b1) rstHigh++;
      compareValue("rstOut", rstOut, (i == 0));
      compareValue("write enables", {pcWrite, irWrite, brWrite, abWrite, aluOutWrite}, 0);
      compareValue("selects", {aluOp, regDst, aluSrcA, aluSrcB, pcSource}, 0);
    end
    compareValue("rstOut pulse count", rstHigh, 1);
    if (errorCount != errorsBefore) testsFailed++;
    $display("reset check: %s", (errorCount == errorsBefore) ? "passed" : "failed");
  endtask

  // Runs from the falling edge that shows irWrite up to the next such edge
  task automatic runTest(input int idx);
    int         base;
    int         cycles;
    int         pcCount;
    int         brCount;
    int         abCount;
    int         errorsBefore;
    logic [3:0] regDstSeen;
    logic [3:0] lastPcSource;
    logic [7:0] aluOpSeen;
    logic [7:0] srcBSeen;
    logic       aluOutSeen;
    bit         done;
    base         = idx * FieldsPer;
    errorsBefore = errorCount;
    cycles       = 0;
    pcCount      = 0;
    brCount      = 0;
    abCount      = 0;
    regDstSeen   = 4'hf;
    lastPcSource = 4'hf;
    aluOpSeen    = 8'hff;
    srcBSeen     = 8'hff;
    aluOutSeen   = 1'b0;
    done         = 1'b0;
    while (!done) begin
      if (pcWrite) begin
        pcCount++;
        lastPcSource = 4'(pcSource);
      end
      if (brWrite) begin
        brCount++;
        regDstSeen = 4'(regDst);
      end
      if (abWrite) abCount++;
      if (cycles == 3) begin  // First execute cycle
        aluOpSeen  = 8'(aluOp);
        srcBSeen   = 8'(aluSrcB);
        aluOutSeen = aluOutWrite;
      end
      if (cycles == 0) driveInputs(idx);  // Held until the next irWrite
      else @(posedge clk);
      @(negedge clk);
      cycles++;
      done = irWrite;
    end
    compareValue("cycles to irWrite", cycles, testData[base+ColCycles]);
    compareValue("pcWrite count", pcCount, testData[base+ColPcWr]);
    compareValue("abWrite count", abCount, 1);  // One A/B load per fetch
    compareValue("aluOp", aluOpSeen, testData[base+ColAluOp]);
    // Any real ALU operation in that cycle also loads ALUOut
    compareValue("aluOutWrite", aluOutSeen, (testData[base+ColAluOp] != 8'(AluNop)));
    compareValue("regDst", regDstSeen, testData[base+ColRegDst]);
    compareValue("brWrite count", brCount, (testData[base+ColRegDst] != 8'hf));
    compareValue("aluSrcB", srcBSeen, testData[base+ColSrcB]);
    compareValue("pcSource", lastPcSource, testData[base+ColPcSrc]);
    if (errorCount != errorsBefore) testsFailed++;
    $display("test %0d opcode %h funct %h eq %0d gt %0d: %s", idx,
             testData[base+ColOpcode], testData[base+ColFunct], testData[base+ColEq],
             testData[base+ColGt], (errorCount == errorsBefore) ? "passed" : "failed");
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    opcode      = '0;
    offset      = '0;
    eq          = 1'b0;
    gt          = 1'b0;
    cycleCount  = 0;
    cycleLimit  = 0;
    errorCount  = 0;
    testsFailed = 0;
    numTests    = 0;
    for (int i = 0; i < MaxTests * FieldsPer; i++) testData[i] = 8'hff;
    $readmemh("verif/ctrlUnitInput.txt", testData);
    while (numTests < MaxTests && testData[numTests*FieldsPer] != 8'hff) numTests++;
    cycleLimit = numTests * 10 + 40;
    if (numTests == 0) begin
      errorCount++;
      $display("No tests were found in the stimulus file");
    end

    checkReset();
    do @(negedge clk); while (irWrite !== 1'b1);  // First fetch out of reset
    for (int i = 0; i < numTests; i++) runTest(i);

    $display("%0d tests run, %0d passed, %0d failed, %0d mismatches", numTests + 1,
             numTests + 1 - testsFailed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ctrlUnit.sv */
`default_nettype none

module ctrlUnit #(
  parameter int MemWaitCycles = 3
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire  [ctrlPkg::OpcodeWidth-1:0] opcode,
  input  wire  [ctrlPkg::OffsetWidth-1:0] offset,
  input  wire                             eq,
  input  wire                             gt,
  output wire                             pcWrite,
  output wire                             irWrite,
  output wire                             brWrite,
  output wire                             abWrite,
  output wire                             aluOutWrite,
  output wire  [ctrlPkg::AluOpWidth-1:0]  aluOp,
  output wire  [1:0]                      regDst,
  output wire  [1:0]                      aluSrcA,
  output wire  [1:0]                      aluSrcB,
  output wire  [2:0]                      pcSource,
  output wire                             rstOut
);

  import ctrlPkg::*;

  wire [ClassWidth-1:0] instrClass;
  wire [ClassWidth-1:0] heldClass;
  wire [PhaseWidth-1:0] phase;
  wire [StepWidth-1:0]  step;

  instrDecoder u_instrDecoder (
    .opcode     (opcode),
    .funct      (offset[5:0]),  // Funct sits in the low offset bits
    .instrClass (instrClass)
  );

  stepSequencer #(
    .MemWaitCycles (MemWaitCycles)
  ) u_stepSequencer (
    .clk        (clk),
    .reset      (reset),
    .instrClass (instrClass),
    .phase      (phase),
    .step       (step),
    .heldClass  (heldClass),
    .rstOut     (rstOut)
  );

  controlEncoder #(
    .MemWaitCycles (MemWaitCycles)
  ) u_controlEncoder (
    .clk         (clk),
    .reset       (reset),
    .phase       (phase),
    .step        (step),
    .heldClass   (heldClass),
    .eq          (eq),
    .gt          (gt),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .brWrite     (brWrite),
    .abWrite     (abWrite),
    .aluOutWrite (aluOutWrite),
    .aluOp       (aluOp),
    .regDst      (regDst),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource)
  );

endmodule

`default_nettype wire

/* verilog/controlEncoder.sv */
`default_nettype none

module controlEncoder #(
  parameter int MemWaitCycles = 3
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire  [ctrlPkg::PhaseWidth-1:0]  phase,
  input  wire  [ctrlPkg::StepWidth-1:0]   step,
  input  wire  [ctrlPkg::ClassWidth-1:0]  heldClass,
  input  wire                             eq,
  input  wire                             gt,
  output logic                            pcWrite,
  output logic                            irWrite,
  output logic                            brWrite,
  output logic                            abWrite,
  output logic                            aluOutWrite,
  output logic [ctrlPkg::AluOpWidth-1:0]  aluOp,
  output logic [1:0]                      regDst,
  output logic [1:0]                      aluSrcA,
  output logic [1:0]                      aluSrcB,
  output logic [2:0]                      pcSource
);

  import ctrlPkg::*;

  localparam logic [StepWidth-1:0] WriteStep = StepWidth'(MemWaitCycles);      // PC and IR
  localparam logic [StepWidth-1:0] LoadStep  = StepWidth'(MemWaitCycles + 1);  // A and B

  logic                  pcWriteNext;
  logic                  irWriteNext;
  logic                  brWriteNext;
  logic                  abWriteNext;
  logic                  aluOutWriteNext;
  logic [AluOpWidth-1:0] aluOpNext;
  logic [1:0]            regDstNext;
  logic [1:0]            aluSrcANext;
  logic [1:0]            aluSrcBNext;
  logic [2:0]            pcSourceNext;
  logic                  taken;
  logic                  isAddi;
  logic [AluOpWidth-1:0] classOp;

  assign isAddi = (heldClass == ClsAddi);

  // Branch condition from the ALU compare flags
  always_comb begin
    case (heldClass)
      ClsBeq:  taken = eq;
      ClsBne:  taken = !eq;
      ClsBle:  taken = !gt;
      ClsBgt:  taken = gt;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (heldClass)
      ClsSub:  classOp = AluSub;
      ClsAnd:  classOp = AluAnd;
      default: classOp = AluAdd;  // ADD and ADDI
    endcase
  end

  always_comb begin
    pcWriteNext     = 1'b0;
    irWriteNext     = 1'b0;
    brWriteNext     = 1'b0;
    abWriteNext     = 1'b0;
    aluOutWriteNext = 1'b0;
    aluOpNext       = AluNop;
    regDstNext      = DstRt;
    aluSrcANext     = SrcAPc;
    aluSrcBNext     = SrcBRegB;
    pcSourceNext    = PcSrcEpc;
    case (phase)
      PhFetch: begin
        if (step < WriteStep) begin
          // Memory wait while the ALU forms PC+4
          aluOutWriteNext = 1'b1;
          aluOpNext       = AluAdd;
          aluSrcANext     = SrcAPc;
          aluSrcBNext     = SrcBFour;
          pcSourceNext    = PcSrcAluResult;
        end else if (step == WriteStep) begin
          pcWriteNext  = 1'b1;
          irWriteNext  = 1'b1;
          pcSourceNext = PcSrcAluOut;
        end else if (step == LoadStep) begin
          abWriteNext = 1'b1;
        end
      end
      PhAlu: begin
        if (step == 3'd0) begin
          aluOutWriteNext = 1'b1;
          aluOpNext       = classOp;
          aluSrcANext     = SrcARegA;
          aluSrcBNext     = isAddi ? SrcBImm : SrcBRegB;
        end else if (step == 3'd1) begin
          brWriteNext = 1'b1;                  // Write back from ALUOut
          regDstNext  = isAddi ? DstRt : DstRd;
        end
      end
      PhBranch: begin
        if (step == 3'd0) begin
          // Target address into ALUOut
          aluOutWriteNext = 1'b1;
          aluOpNext       = AluAdd;
          aluSrcANext     = SrcAPc;
          aluSrcBNext     = SrcBBranchOff;
        end else if (step == 3'd1 || step == 3'd2) begin
          aluOpNext    = AluCmp;
          aluSrcANext  = SrcARegA;
          aluSrcBNext  = SrcBRegB;
          pcSourceNext = PcSrcAluOut;
          pcWriteNext  = (step == 3'd2) && taken;  // Flags settle in step 1
        end
      end
      PhRte: begin
        if (step == 3'd0) begin
          pcWriteNext  = 1'b1;
          pcSourceNext = PcSrcEpc;
        end
      end
      default: ;  // PhReset and PhBreak drive nothing
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcWrite     <= 1'b0;
      irWrite     <= 1'b0;
      brWrite     <= 1'b0;
      abWrite     <= 1'b0;
      aluOutWrite <= 1'b0;
      aluOp       <= AluNop;
      regDst      <= DstRt;
      aluSrcA     <= SrcAPc;
      aluSrcB     <= SrcBRegB;
      pcSource    <= PcSrcEpc;
    end else begin
      pcWrite     <= pcWriteNext;
      irWrite     <= irWriteNext;
      brWrite     <= brWriteNext;
      abWrite     <= abWriteNext;
      aluOutWrite <= aluOutWriteNext;
      aluOp       <= aluOpNext;
      regDst      <= regDstNext;
      aluSrcA     <= aluSrcANext;
      aluSrcB     <= aluSrcBNext;
      pcSource    <= pcSourceNext;
    end
  end

  // IR only loads together with the new PC
  assert property (@(posedge clk) disable iff (reset) irWrite |-> pcWrite)
    else $error("irWrite without pcWrite");

  // ALUOut would be overwritten while it feeds the PC
  assert property (@(posedge clk) disable iff (reset) !(pcWrite && aluOutWrite))
    else $error("pcWrite and aluOutWrite both high");

endmodule

`default_nettype wire

/* verilog/stepSequencer.sv */
`default_nettype none

module stepSequencer #(
  parameter int MemWaitCycles = 3
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire  [ctrlPkg::ClassWidth-1:0]  instrClass,
  output logic [ctrlPkg::PhaseWidth-1:0]  phase,
  output logic [ctrlPkg::StepWidth-1:0]   step,
  output logic [ctrlPkg::ClassWidth-1:0]  heldClass,
  output logic                            rstOut
);

  import ctrlPkg::*;

  // Fetch ends with the decode step
  localparam logic [StepWidth-1:0] DecodeStep = StepWidth'(MemWaitCycles + 2);

  // Last step of each execute phase
  localparam logic [StepWidth-1:0] AluLast    = 3'd2;
  localparam logic [StepWidth-1:0] BranchLast = 3'd3;
  localparam logic [StepWidth-1:0] BreakLast  = 3'd0;
  localparam logic [StepWidth-1:0] RteLast    = 3'd1;

  logic                  resetQ;     // Reset seen on the previous edge
  logic [StepWidth-1:0]  lastStep;
  logic [PhaseWidth-1:0] classPhase;
  logic                  decodeNow;

  always_comb begin
    case (phase)
      PhFetch:  lastStep = DecodeStep;
      PhAlu:    lastStep = AluLast;
      PhBranch: lastStep = BranchLast;
      PhBreak:  lastStep = BreakLast;
      PhRte:    lastStep = RteLast;
      default:  lastStep = '0;  // PhReset and unused codes leave at once
    endcase
  end

  // Phase entered after decode
  always_comb begin
    case (instrClass)
      ClsAdd, ClsSub, ClsAnd, ClsAddi: classPhase = PhAlu;
      ClsBeq, ClsBne, ClsBle, ClsBgt:  classPhase = PhBranch;
      ClsBreak:                        classPhase = PhBreak;
      ClsRte:                          classPhase = PhRte;
      default:                         classPhase = PhFetch;  // Refetch
    endcase
  end

  assign decodeNow = (phase == PhFetch) && (step == DecodeStep);

  always_ff @(posedge clk) begin
    resetQ <= reset;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step <= '0;
      if (resetQ) begin
        phase  <= PhFetch;
        rstOut <= 1'b0;
      end else begin
        // First reset cycle only
        phase  <= PhReset;
        rstOut <= 1'b1;
      end
    end else begin
      rstOut <= 1'b0;
      if (decodeNow) begin
        phase <= classPhase;
        step  <= '0;
      end else if (step == lastStep) begin
        phase <= PhFetch;  // Also the way out of PhReset
        step  <= '0;
      end else begin
        step <= step + 1'b1;
      end
    end
  end

  // Class stays put for the whole execute phase
  always_ff @(posedge clk) begin
    if (decodeNow) heldClass <= instrClass;
  end

  assert property (@(posedge clk) disable iff (reset) step <= lastStep)
    else $error("step %0d past end of phase %0d", step, phase);

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  wire  [ctrlPkg::OpcodeWidth-1:0] opcode,
  input  wire  [5:0]                      funct,
  output logic [ctrlPkg::ClassWidth-1:0]  instrClass
);

  import ctrlPkg::*;

  // R-type instructions are told apart by funct alone
  always_comb begin
    instrClass = ClsNone;
    case (opcode)
      OpRType: begin
        case (funct)
          FnAdd:   instrClass = ClsAdd;
          FnSub:   instrClass = ClsSub;
          FnAnd:   instrClass = ClsAnd;
          FnBreak: instrClass = ClsBreak;
          FnRte:   instrClass = ClsRte;
          default: instrClass = ClsNone;  // Shifts, mult, div and the rest
        endcase
      end
      OpAddi:  instrClass = ClsAddi;
      OpBeq:   instrClass = ClsBeq;
      OpBne:   instrClass = ClsBne;
      OpBle:   instrClass = ClsBle;
      OpBgt:   instrClass = ClsBgt;
      default: instrClass = ClsNone;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  // Instruction field widths
  localparam int OpcodeWidth = 6;
  localparam int OffsetWidth = 16;

  // Opcodes
  localparam logic [OpcodeWidth-1:0] OpRType = 6'b000000;  // Decoded further by funct
  localparam logic [OpcodeWidth-1:0] OpBeq   = 6'b000100;
  localparam logic [OpcodeWidth-1:0] OpBne   = 6'b000101;
  localparam logic [OpcodeWidth-1:0] OpBle   = 6'b000110;
  localparam logic [OpcodeWidth-1:0] OpBgt   = 6'b000111;
  localparam logic [OpcodeWidth-1:0] OpAddi  = 6'b001000;

  // Funct codes, low six bits of the offset
  localparam logic [5:0] FnBreak = 6'b001011;
  localparam logic [5:0] FnRte   = 6'b010011;
  localparam logic [5:0] FnAdd   = 6'b100000;
  localparam logic [5:0] FnSub   = 6'b100010;
  localparam logic [5:0] FnAnd   = 6'b100100;

  // Instruction classes
  localparam int ClassWidth = 4;
  localparam logic [ClassWidth-1:0] ClsNone  = 4'd0;  // Unknown, refetch
  localparam logic [ClassWidth-1:0] ClsAdd   = 4'd1;
  localparam logic [ClassWidth-1:0] ClsSub   = 4'd2;
  localparam logic [ClassWidth-1:0] ClsAnd   = 4'd3;
  localparam logic [ClassWidth-1:0] ClsAddi  = 4'd4;
  localparam logic [ClassWidth-1:0] ClsBeq   = 4'd5;
  localparam logic [ClassWidth-1:0] ClsBne   = 4'd6;
  localparam logic [ClassWidth-1:0] ClsBle   = 4'd7;
  localparam logic [ClassWidth-1:0] ClsBgt   = 4'd8;
  localparam logic [ClassWidth-1:0] ClsBreak = 4'd9;
  localparam logic [ClassWidth-1:0] ClsRte   = 4'd10;

  // Sequencer phases
  // All ALU classes share PhAlu and all branches share PhBranch
  localparam int PhaseWidth = 3;
  localparam logic [PhaseWidth-1:0] PhReset  = 3'd0;
  localparam logic [PhaseWidth-1:0] PhFetch  = 3'd1;
  localparam logic [PhaseWidth-1:0] PhAlu    = 3'd2;
  localparam logic [PhaseWidth-1:0] PhBranch = 3'd3;
  localparam logic [PhaseWidth-1:0] PhBreak  = 3'd4;
  localparam logic [PhaseWidth-1:0] PhRte    = 3'd5;

  localparam int StepWidth = 3;

  // ALU operations
  localparam int AluOpWidth = 3;
  localparam logic [AluOpWidth-1:0] AluNop = 3'd0;
  localparam logic [AluOpWidth-1:0] AluAdd = 3'd1;
  localparam logic [AluOpWidth-1:0] AluSub = 3'd2;
  localparam logic [AluOpWidth-1:0] AluAnd = 3'd3;
  localparam logic [AluOpWidth-1:0] AluCmp = 3'd7;  // Sets eq and gt

  // ALU operand A
  localparam logic [1:0] SrcAPc   = 2'd0;
  localparam logic [1:0] SrcARegA = 2'd1;

  // ALU operand B
  localparam logic [1:0] SrcBRegB      = 2'd0;
  localparam logic [1:0] SrcBFour      = 2'd1;
  localparam logic [1:0] SrcBImm       = 2'd2;  // Sign extended offset
  localparam logic [1:0] SrcBBranchOff = 2'd3;  // Offset shifted left by two

  // Register file write address
  localparam logic [1:0] DstRt = 2'd0;
  localparam logic [1:0] DstRd = 2'd1;

  // Next PC source
  localparam logic [2:0] PcSrcEpc       = 3'd0;
  localparam logic [2:0] PcSrcAluResult = 3'd1;
  localparam logic [2:0] PcSrcAluOut    = 3'd2;

endpackage

`default_nettype wire
